//--- source/dcache_pkg.sv
package dcache_pkg;

    ////////////////////
    // cache geometry
    ////////////////////

    // byte address split into tag, set index and line offset
    localparam int ADDR_W   = 32;
    localparam int TAG_W    = 20;
    localparam int INDEX_W  = 7;
    localparam int OFFSET_W = 5;

    // eight words per line, one bank each
    localparam int WORDS    = 8;
    localparam int SETS     = 128;
    localparam int LINE_W   = 256;

    ////////////////////
    // field types
    ////////////////////

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [INDEX_W-1:0]  index_t;

    // cpu side word and its byte strobes
    typedef logic [31:0]         word_t;
    typedef logic [3:0]          wstrb_t;

    // whole line as seen by memory and the ways
    typedef logic [LINE_W-1:0]   line_t;

    // one enable per byte of a line
    typedef logic [LINE_W/8-1:0] line_strb_t;

endpackage

//--- source/way_if.sv
interface way_if;
    import dcache_pkg::*;

    // from the controller
    index_t     rd_index;
    index_t     req_index;
    tag_t       req_tag;
    logic       wr_en;
    line_strb_t wr_strb;
    line_t      wr_line;

    // from the way, for the set read last cycle
    logic       hit;
    line_t      line;
    tag_t       line_tag;
    logic       line_valid;

    modport ctrl (
        output rd_index, req_index, req_tag, wr_en, wr_strb, wr_line,
        input  hit, line, line_tag, line_valid
    );

    modport way (
        input  rd_index, req_index, req_tag, wr_en, wr_strb, wr_line,
        output hit, line, line_tag, line_valid
    );

endinterface

//--- source/dcache_way.sv
module dcache_way (
    input  logic clk,
    input  logic rst,
    way_if.way   bus
);
    import dcache_pkg::*;

    tag_t            tag_mem [SETS];
    logic [SETS-1:0] valid_bits;
    tag_t            tag_rd;
    logic            valid_rd;
    line_t           bank_line;
    logic            collide;
    line_t           fwd_line;
    tag_t            fwd_tag;

    ////////////////////
    // tag and valid
    ////////////////////

    always_ff @(posedge clk) begin
        if (bus.wr_en) begin
            tag_mem[bus.req_index] <= bus.req_tag;
        end
        tag_rd <= tag_mem[bus.rd_index];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_bits <= '0;
            valid_rd   <= 1'b0;
            collide    <= 1'b0;
        end else begin
            if (bus.wr_en) begin
                valid_bits[bus.req_index] <= 1'b1;
            end
            valid_rd <= valid_bits[bus.rd_index];
            // read and write hit the same set on this edge
            collide  <= bus.wr_en && (bus.rd_index == bus.req_index);
        end
    end

    ////////////////////
    // word banks
    ////////////////////

    for (genvar w = 0; w < WORDS; w++) begin : g_bank
        word_t mem [SETS];
        word_t rd_word;

        always_ff @(posedge clk) begin
            for (int b = 0; b < 4; b++) begin
                if (bus.wr_en && bus.wr_strb[w*4+b]) begin
                    mem[bus.req_index][b*8 +: 8] <= bus.wr_line[w*32+b*8 +: 8];
                end
            end
            rd_word <= mem[bus.rd_index];
        end

        assign bank_line[w*32 +: 32] = rd_word;
    end

    // written line and tag, returned on a collision
    always_ff @(posedge clk) begin
        fwd_line <= bus.wr_line;
        fwd_tag  <= bus.req_tag;
    end

    assign bus.line       = collide ? fwd_line : bank_line;
    assign bus.line_tag   = collide ? fwd_tag : tag_rd;
    assign bus.line_valid = collide | valid_rd;
    assign bus.hit        = bus.line_valid && (bus.line_tag == bus.req_tag);

    // a write always touches at least one byte, else the tag would update alone
    a_strb_nonzero: assert property (
        @(posedge clk) disable iff (!rst)
        bus.wr_en |-> |bus.wr_strb
    );

endmodule

//--- source/dcache_ctrl.sv
module dcache_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               req_i,
    input  logic               we_i,
    input  dcache_pkg::addr_t  addr_i,
    input  dcache_pkg::wstrb_t wstrb_i,
    input  dcache_pkg::word_t  wdata_i,
    output logic               stall_o,
    output logic               data_ok_o,
    output dcache_pkg::word_t  rdata_o,
    output logic               rd_req_o,
    output dcache_pkg::addr_t  rd_addr_o,
    input  logic               ret_valid_i,
    input  dcache_pkg::line_t  ret_data_i,
    output logic               wr_req_o,
    output dcache_pkg::addr_t  wr_addr_o,
    output dcache_pkg::line_t  wr_data_o,
    input  logic               wr_valid_i,
    way_if.ctrl                way0,
    way_if.ctrl                way1
);
    import dcache_pkg::*;

    logic                lk_valid;
    logic                lk_we;
    addr_t               lk_addr;
    wstrb_t              lk_strb;
    word_t               lk_wdata;
    tag_t                lk_tag;
    index_t              lk_index;
    logic [OFFSET_W-3:0] lk_word;
    logic                hit0, hit1, hit, miss, idle;
    logic                wb_q, rf_q, refill_done;
    logic [SETS-1:0]     lru, dirty0, dirty1;
    logic                victim, victim_valid, victim_dirty;
    tag_t                victim_tag;
    line_t               victim_line, base_line, merged_line;
    line_strb_t          req_strb;

    ////////////////////
    // lookup stage
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            lk_valid <= 1'b0;
        end else if (!stall_o) begin
            lk_valid <= req_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            lk_we    <= we_i;
            lk_addr  <= addr_i;
            lk_strb  <= wstrb_i;
            lk_wdata <= wdata_i;
        end
    end

    assign lk_tag   = lk_addr[ADDR_W-1 -: TAG_W];
    assign lk_index = lk_addr[OFFSET_W +: INDEX_W];
    assign lk_word  = lk_addr[OFFSET_W-1:2];

    // held set is re-read every cycle of a stall
    assign way0.rd_index  = stall_o ? lk_index : addr_i[OFFSET_W +: INDEX_W];
    assign way1.rd_index  = way0.rd_index;
    assign way0.req_index = lk_index;
    assign way1.req_index = lk_index;
    assign way0.req_tag   = lk_tag;
    assign way1.req_tag   = lk_tag;

    assign hit0        = lk_valid && way0.hit;
    assign hit1        = lk_valid && way1.hit;
    assign hit         = hit0 || hit1;
    assign idle        = !wb_q && !rf_q;
    assign miss        = lk_valid && !hit && idle;
    assign refill_done = rf_q && ret_valid_i;

    ////////////////////
    // victim and merge
    ////////////////////

    assign victim       = lru[lk_index];
    assign victim_line  = victim ? way1.line : way0.line;
    assign victim_tag   = victim ? way1.line_tag : way0.line_tag;
    assign victim_valid = victim ? way1.line_valid : way0.line_valid;
    assign victim_dirty = victim ? dirty1[lk_index] : dirty0[lk_index];

    assign base_line = rf_q ? ret_data_i : (hit1 ? way1.line : way0.line);

    always_comb begin
        req_strb = '0;
        if (lk_we) begin
            req_strb[lk_word*4 +: 4] = lk_strb;
        end
        merged_line = base_line;
        for (int i = 0; i < LINE_W/8; i++) begin
            if (req_strb[i]) begin
                merged_line[i*8 +: 8] = lk_wdata[(i % 4)*8 +: 8];
            end
        end
    end

    // write hit touches only its bytes, refill writes the whole line
    assign way0.wr_en   = (hit0 && |req_strb) || (refill_done && !victim);
    assign way1.wr_en   = (hit1 && |req_strb) || (refill_done && victim);
    assign way0.wr_strb = refill_done ? '1 : req_strb;
    assign way1.wr_strb = way0.wr_strb;
    assign way0.wr_line = merged_line;
    assign way1.wr_line = merged_line;

    ////////////////////
    // lru, dirty, fsm
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            lru    <= '0;
            dirty0 <= '0;
            dirty1 <= '0;
        end else begin
            // bit names the way to evict next
            if (hit) begin
                lru[lk_index] <= hit0;
            end else if (refill_done) begin
                lru[lk_index] <= !victim;
            end
            if (way0.wr_en) begin
                dirty0[lk_index] <= lk_we;
            end
            if (way1.wr_en) begin
                dirty1[lk_index] <= lk_we;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_q <= 1'b0;
            rf_q <= 1'b0;
        end else if (wb_q) begin
            if (wr_valid_i) begin
                wb_q <= 1'b0;
                rf_q <= 1'b1;
            end
        end else if (rf_q) begin
            if (ret_valid_i) begin
                rf_q <= 1'b0;
            end
        end else if (miss) begin
            wb_q <= victim_valid && victim_dirty;
            rf_q <= !(victim_valid && victim_dirty);
        end
    end

    assign stall_o   = lk_valid && !hit && !refill_done;
    assign data_ok_o = lk_valid && !lk_we && (hit || refill_done);
    assign rdata_o   = base_line[lk_word*32 +: 32];

    assign wr_req_o  = wb_q;
    assign wr_addr_o = {victim_tag, lk_index, {OFFSET_W{1'b0}}};
    assign wr_data_o = victim_line;
    assign rd_req_o  = rf_q;
    assign rd_addr_o = {lk_tag, lk_index, {OFFSET_W{1'b0}}};

    a_one_hit: assert property (
        @(posedge clk) disable iff (!rst)
        !(hit0 && hit1)
    );

    a_mem_excl: assert property (
        @(posedge clk) disable iff (!rst)
        !(rd_req_o && wr_req_o)
    );

endmodule

//--- source/dcache_top.sv
module dcache_top (
    input  logic               clk,
    input  logic               rst,
    // cpu side
    input  logic               req_i,
    input  logic               we_i,
    input  dcache_pkg::addr_t  addr_i,
    input  dcache_pkg::wstrb_t wstrb_i,
    input  dcache_pkg::word_t  wdata_i,
    output logic               stall_o,
    output logic               data_ok_o,
    output dcache_pkg::word_t  rdata_o,
    // memory side
    output logic               rd_req_o,
    output dcache_pkg::addr_t  rd_addr_o,
    input  logic               ret_valid_i,
    input  dcache_pkg::line_t  ret_data_i,
    output logic               wr_req_o,
    output dcache_pkg::addr_t  wr_addr_o,
    output dcache_pkg::line_t  wr_data_o,
    input  logic               wr_valid_i
);

    way_if way0_bus ();
    way_if way1_bus ();

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .wstrb_i     (wstrb_i),
        .wdata_i     (wdata_i),
        .stall_o     (stall_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i),
        .wr_req_o    (wr_req_o),
        .wr_addr_o   (wr_addr_o),
        .wr_data_o   (wr_data_o),
        .wr_valid_i  (wr_valid_i),
        .way0        (way0_bus.ctrl),
        .way1        (way1_bus.ctrl)
    );

    // ways are identical, the controller tells them apart
    dcache_way u_way0 (
        .clk (clk),
        .rst (rst),
        .bus (way0_bus.way)
    );

    dcache_way u_way1 (
        .clk (clk),
        .rst (rst),
        .bus (way1_bus.way)
    );

endmodule

//--- test/mem_model.sv
module mem_model #(
    parameter int unsigned       SEED = 0,
    parameter dcache_pkg::word_t RULE = '0
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              rd_req_i,
    input  dcache_pkg::addr_t rd_addr_i,
    output logic              ret_valid_o,
    output dcache_pkg::line_t ret_data_o,
    input  logic              wr_req_i,
    input  dcache_pkg::addr_t wr_addr_i,
    input  dcache_pkg::line_t wr_data_i,
    output logic              wr_valid_o
);
    import dcache_pkg::*;

    // memory as written back, and memory as the cpu expects it
    localparam bit STORED = 1'b0;
    localparam bit EXPECT = 1'b1;

    word_t words [logic [ADDR_W:0]];
    int    errors;

    function automatic word_t get_word(bit sel, addr_t a);
        if (words.exists({sel, a})) begin
            return words[{sel, a}];
        end
        return a ^ RULE;
    endfunction

    function automatic line_t get_line(bit sel, addr_t base);
        line_t l;
        for (int w = 0; w < WORDS; w++) begin
            l[w*32 +: 32] = get_word(sel, base + addr_t'(w * 4));
        end
        return l;
    endfunction

    // every accepted cpu write lands here
    task automatic note_write(addr_t a, wstrb_t strb, word_t data);
        word_t cur;
        cur = get_word(EXPECT, {a[ADDR_W-1:2], 2'b00});
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                cur[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        words[{EXPECT, a[ADDR_W-1:2], 2'b00}] = cur;
    endtask

    initial begin : respond
        int unsigned delay;
        errors      = 0;
        ret_valid_o = 1'b0;
        ret_data_o  = '0;
        wr_valid_o  = 1'b0;
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #1;
            if (rst && (wr_req_i || rd_req_i)) begin
                delay = $urandom % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                if (wr_req_i) begin
                    // a clean line matches what memory already holds
                    assert (get_line(EXPECT, wr_addr_i) != get_line(STORED, wr_addr_i))
                    else begin
                        errors++;
                        $display("Fail at %0t: line %h written back while clean",
                                 $time, wr_addr_i);
                    end
                    assert (wr_data_i == get_line(EXPECT, wr_addr_i)) else begin
                        errors++;
                        $display("Fail at %0t: write-back of line %h carries %h",
                                 $time, wr_addr_i, wr_data_i);
                    end
                    for (int w = 0; w < WORDS; w++) begin
                        words[{STORED, wr_addr_i + addr_t'(w * 4)}] = wr_data_i[w*32 +: 32];
                    end
                    wr_valid_o = 1'b1;
                end else begin
                    ret_data_o  = get_line(STORED, rd_addr_i);
                    ret_valid_o = 1'b1;
                end
                @(posedge clk);
                #1;
                wr_valid_o  = 1'b0;
                ret_valid_o = 1'b0;
            end
        end
    end

endmodule

//--- test/dcache_tb.sv
module dcache_tb;
    import dcache_pkg::*;

    localparam int unsigned SEED     = 32'h6e75d0fc;
    localparam word_t       MEM_RULE = 32'hffff_0000;
    localparam int          PERIOD   = 8;

    typedef struct packed {
        logic   we;
        addr_t  addr;
        wstrb_t strb;
        word_t  wdata;
        word_t  rdata;
        logic   miss;
    } req_t;

    logic   clk, rst, req_i, we_i, stall_o, data_ok_o;
    logic   rd_req_o, ret_valid_i, wr_req_o, wr_valid_i;
    addr_t  addr_i, rd_addr_o, wr_addr_o;
    wstrb_t wstrb_i;
    word_t  wdata_i, rdata_o;
    line_t  ret_data_i, wr_data_o;

    req_t trace[$];
    req_t pending[$];
    int   cur = 0;
    int   refills = 0;
    logic rd_prev = 1'b0;
    int   read_errors = 0;
    int   refill_errors = 0;
    int   other_errors = 0;

    dcache_top DUT (.*);

    mem_model #(.SEED(SEED), .RULE(MEM_RULE)) u_mem (
        .clk         (clk),
        .rst         (rst),
        .rd_req_i    (rd_req_o),
        .rd_addr_i   (rd_addr_o),
        .ret_valid_o (ret_valid_i),
        .ret_data_o  (ret_data_i),
        .wr_req_i    (wr_req_o),
        .wr_addr_i   (wr_addr_o),
        .wr_data_i   (wr_data_o),
        .wr_valid_o  (wr_valid_i)
    );

    initial clk = 1'b0;
    always #(PERIOD/2) clk = ~clk;

    task automatic end_run();
        $display("errors: read %0d, refill %0d, write-back %0d, other %0d",
                 read_errors, refill_errors, u_mem.errors, other_errors);
        if (read_errors + refill_errors + u_mem.errors + other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic load_trace();
        int     fd;
        string  text;
        string  op;
        addr_t  a;
        wstrb_t s;
        word_t  d;
        word_t  e;
        int     m;
        fd = $fopen("test/dcache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file test/dcache_trace.txt");
            other_errors++;
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() > 1 && text[0] != "#") begin
                if ($sscanf(text, "%s %h %h %h %h %d", op, a, s, d, e, m) == 6) begin
                    trace.push_back({op == "W", a, s, d, e, m[0]});
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic check_refills(int idx);
        assert (refills == int'(trace[idx].miss)) else begin
            refill_errors++;
            $display("Fail at %0t: request %0d to %h made %0d refills, expected %0d",
                     $time, idx, trace[idx].addr, refills, trace[idx].miss);
        end
    endtask

    ////////////////////
    // stimulus
    ////////////////////

    initial begin : drive
        rst     = 1'b0;
        req_i   = 1'b0;
        we_i    = 1'b0;
        addr_i  = '0;
        wstrb_i = '0;
        wdata_i = '0;
        load_trace();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b1;
        for (int i = 0; i < trace.size(); i++) begin
            cur     = i;
            req_i   = 1'b1;
            we_i    = trace[i].we;
            addr_i  = trace[i].addr;
            wstrb_i = trace[i].strb;
            wdata_i = trace[i].wdata;
            // held until a cycle without stall
            @(negedge clk);
            while (stall_o) begin
                @(negedge clk);
            end
            @(posedge clk);
            #1;
        end
        req_i = 1'b0;
        // last request may still be missing
        @(negedge clk);
        while (stall_o) begin
            @(negedge clk);
        end
        @(posedge clk);
        if (trace.size() > 0) begin
            check_refills(trace.size() - 1);
        end
        if (pending.size() != 0) begin
            $display("%0d reads never returned data", pending.size());
            other_errors++;
        end
        end_run();
    end

    ////////////////////
    // checking
    ////////////////////

    always @(negedge clk) begin : monitor
        req_t r;
        if (rst) begin
            if (rd_req_o && !rd_prev) begin
                refills++;
            end
            rd_prev = rd_req_o;
            if (data_ok_o) begin
                if (pending.size() == 0) begin
                    $display("read data returned at %0t with no read outstanding", $time);
                    other_errors++;
                end else begin
                    r = pending.pop_front();
                    assert (rdata_o == r.rdata) else begin
                        read_errors++;
                        $display("Fail at %0t: read of %h returned %h, expected %h",
                                 $time, r.addr, rdata_o, r.rdata);
                    end
                end
            end
            // accepted on the coming edge
            if (req_i && !stall_o) begin
                if (cur > 0) begin
                    check_refills(cur - 1);
                end
                refills = 0;
                if (trace[cur].we) begin
                    u_mem.note_write(addr_i, wstrb_i, wdata_i);
                end else begin
                    pending.push_back(trace[cur]);
                end
            end
        end
    end

    initial begin : watchdog
        #1;
        #((trace.size() * 40 + 100) * PERIOD);
        $display("timeout: the test hung and did not finish the trace");
        other_errors++;
        end_run();
    end

endmodule

//--- filelist.f
source/dcache_pkg.sv
source/way_if.sv
source/dcache_way.sv
source/dcache_ctrl.sv
source/dcache_top.sv
test/mem_model.sv
test/dcache_tb.sv

//--- test/dcache_trace.txt
# op addr strb wdata rdata miss
# op is R or W, rdata is checked on reads only, miss is the expected refill count
# cold miss in set 0, then back to back hits
R 00001004 0 00000000 ffff1004 1
R 00001000 0 00000000 ffff1000 0
R 0000101c 0 00000000 ffff101c 0
R 00001004 0 00000000 ffff1004 0
# partial write hit, read right behind it in the same set
W 00001008 3 aabbccdd 00000000 0
R 00001008 0 00000000 ffffccdd 0
# write miss allocates in set 2
W 00003054 c 12345678 00000000 1
R 00003054 0 00000000 12343054 0
R 00003050 0 00000000 ffff3050 0
# set 5: A and B fill both ways, A touched, C evicts dirty B
R 000050a0 0 00000000 ffff50a0 1
W 000160a4 f deadbeef 00000000 1
R 000160a4 0 00000000 deadbeef 0
R 000050a0 0 00000000 ffff50a0 0
R 000270a8 0 00000000 fffd70a8 1
R 000050a4 0 00000000 ffff50a4 0
R 000160a4 0 00000000 deadbeef 1
# set 0: dirty line 1000 evicted, then read back from memory
R 00002000 0 00000000 ffff2000 1
R 00003000 0 00000000 ffff3000 1
R 00001008 0 00000000 ffffccdd 1
R 0000100c 0 00000000 ffff100c 0
